// ==== src/la_pkg.sv ====
package la_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // 3R format, inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // 2RI12 format, inst[31:22]
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_b   = 10'h0a0;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_b   = 10'h0a4;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    // 1RI20 format, inst[31:25]
    localparam logic [6:0] op_lu12i_w = 7'h0a;

    // branch formats, inst[31:26]
    localparam logic [5:0] op_b   = 6'h14;
    localparam logic [5:0] op_beq = 6'h16;
    localparam logic [5:0] op_bne = 6'h17;

    // add is the zero code, so a cleared payload is harmless
    typedef enum logic [2:0] {
        alu_add      = 3'd0,
        alu_sub      = 3'd1,
        alu_and      = 3'd2,
        alu_or       = 3'd3,
        alu_xor      = 3'd4,
        alu_lui_pass = 3'd5
    } alu_op_e;

    typedef struct packed {
        alu_op_e  alu_op;
        word_t    op_a;
        word_t    op_b;
        word_t    store_data;
        reg_idx_t rd;
        logic     we;
        logic     mem_read;
        logic     mem_write;
        logic     mem_byte;
    } id_ex_t;

    typedef struct packed {
        word_t    result;
        word_t    store_data;
        reg_idx_t rd;
        logic     we;
        logic     mem_read;
        logic     mem_write;
        logic     mem_byte;
    } ex_mem_t;

    typedef struct packed {
        word_t    wdata;
        reg_idx_t rd;
        logic     we;
    } mem_wb_t;

endpackage

// ==== src/la_fwd_if.sv ====
`timescale 1ns/100ps

interface la_fwd_if;
    import la_pkg::*;

    logic     ex_we;
    reg_idx_t ex_rd;
    word_t    ex_data;
    logic     ex_is_load;
    logic     mem_we;
    reg_idx_t mem_rd;
    word_t    mem_data;

    modport producer (
        output ex_we, ex_rd, ex_data, ex_is_load, mem_we, mem_rd, mem_data
    );

    modport consumer (
        input ex_we, ex_rd, ex_data, ex_is_load, mem_we, mem_rd, mem_data
    );

endinterface

// ==== src/la_regfile.sv ====
`timescale 1ns/100ps

module la_regfile (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             we_i,
    input  la_pkg::reg_idx_t waddr_i,
    input  la_pkg::word_t    wdata_i,
    input  la_pkg::reg_idx_t raddr1_i,
    input  la_pkg::reg_idx_t raddr2_i,
    output la_pkg::word_t    rdata1_o,
    output la_pkg::word_t    rdata2_o
);
    import la_pkg::*;

    word_t regs [32];

    // same-cycle write is visible to the reader
    function automatic word_t read_port(reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

endmodule

// ==== src/la_pipe_reg.sv ====
`timescale 1ns/100ps

module la_pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // all-zero payload carries no enables
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (hold_i) begin
            q_o <= q_o;
        end else if (bubble_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// ==== src/la_fetch.sv ====
`timescale 1ns/100ps

module la_fetch #(
    parameter la_pkg::word_t reset_pc = '0
) (
    input  logic          clk,
    input  logic          arst_n_i,
    input  logic          stall_i,
    input  logic          branch_taken_i,
    input  la_pkg::word_t branch_target_i,
    input  la_pkg::word_t rom_inst_i,
    output la_pkg::word_t pc_o,
    output logic          inst_en_o,
    output la_pkg::word_t id_pc_o,
    output la_pkg::word_t id_inst_o
);
    import la_pkg::*;

    word_t next_pc;

    // first cycle after reset only raises the enable
    always_comb begin
        if (!inst_en_o || stall_i) begin
            next_pc = pc_o;
        end else if (branch_taken_i) begin
            next_pc = branch_target_i;
        end else begin
            next_pc = pc_o + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o      <= reset_pc;
            inst_en_o <= 1'b0;
        end else begin
            pc_o      <= next_pc;
            inst_en_o <= 1'b1;
        end
    end

    // zero word decodes as a nop
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_pc_o   <= '0;
            id_inst_o <= '0;
        end else if (!stall_i) begin
            id_pc_o <= pc_o;
            if (branch_taken_i || !inst_en_o) begin
                id_inst_o <= '0;
            end else begin
                id_inst_o <= rom_inst_i;
            end
        end
    end

endmodule

// ==== src/la_decode.sv ====
`timescale 1ns/100ps

module la_decode (
    input  la_pkg::word_t    id_pc_i,
    input  la_pkg::word_t    id_inst_i,
    input  la_pkg::word_t    rs1_data_i,
    input  la_pkg::word_t    rs2_data_i,
    output la_pkg::reg_idx_t rs1_addr_o,
    output la_pkg::reg_idx_t rs2_addr_o,
    la_fwd_if.consumer       fwd,
    output la_pkg::id_ex_t   payload_o,
    output logic             stall_o,
    output logic             branch_taken_o,
    output la_pkg::word_t    branch_target_o
);
    import la_pkg::*;

    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    logic     is_3r;
    logic     is_addi;
    logic     is_ld_b;
    logic     is_ld_w;
    logic     is_st_b;
    logic     is_st_w;
    logic     is_lu12i;
    logic     is_beq;
    logic     is_bne;
    logic     is_b;
    logic     use_rs1;
    logic     use_rs2;
    word_t    src1;
    word_t    src2;
    word_t    imm;
    word_t    br_offs;
    alu_op_e  alu_op;

    assign rd = id_inst_i[4:0];
    assign rj = id_inst_i[9:5];
    assign rk = id_inst_i[14:10];

    assign is_3r    = (id_inst_i[31:15] == op_add_w) || (id_inst_i[31:15] == op_sub_w) ||
                      (id_inst_i[31:15] == op_and)   || (id_inst_i[31:15] == op_or)    ||
                      (id_inst_i[31:15] == op_xor);
    assign is_addi  = id_inst_i[31:22] == op_addi_w;
    assign is_ld_b  = id_inst_i[31:22] == op_ld_b;
    assign is_ld_w  = id_inst_i[31:22] == op_ld_w;
    assign is_st_b  = id_inst_i[31:22] == op_st_b;
    assign is_st_w  = id_inst_i[31:22] == op_st_w;
    assign is_lu12i = id_inst_i[31:25] == op_lu12i_w;
    assign is_beq   = id_inst_i[31:26] == op_beq;
    assign is_bne   = id_inst_i[31:26] == op_bne;
    assign is_b     = id_inst_i[31:26] == op_b;

    // stores and branches read rd on the second port
    assign rs1_addr_o = rj;
    assign rs2_addr_o = is_3r ? rk : rd;
    assign use_rs1 = is_3r | is_addi | is_ld_b | is_ld_w | is_st_b | is_st_w | is_beq | is_bne;
    assign use_rs2 = is_3r | is_st_b | is_st_w | is_beq | is_bne;

    always_comb begin
        if (rs1_addr_o == '0) begin
            src1 = '0;
        end else if (fwd.ex_we && fwd.ex_rd == rs1_addr_o) begin
            src1 = fwd.ex_data;
        end else if (fwd.mem_we && fwd.mem_rd == rs1_addr_o) begin
            src1 = fwd.mem_data;
        end else begin
            src1 = rs1_data_i;
        end
    end

    always_comb begin
        if (rs2_addr_o == '0) begin
            src2 = '0;
        end else if (fwd.ex_we && fwd.ex_rd == rs2_addr_o) begin
            src2 = fwd.ex_data;
        end else if (fwd.mem_we && fwd.mem_rd == rs2_addr_o) begin
            src2 = fwd.mem_data;
        end else begin
            src2 = rs2_data_i;
        end
    end

    // load result not ready until memory stage
    assign stall_o = fwd.ex_is_load && (fwd.ex_rd != '0) &&
                     ((use_rs1 && fwd.ex_rd == rs1_addr_o) ||
                      (use_rs2 && fwd.ex_rd == rs2_addr_o));

    always_comb begin
        case (id_inst_i[31:15])
            op_sub_w: alu_op = alu_sub;
            op_and:   alu_op = alu_and;
            op_or:    alu_op = alu_or;
            op_xor:   alu_op = alu_xor;
            default:  alu_op = is_lu12i ? alu_lui_pass : alu_add;
        endcase
    end

    assign imm = is_lu12i ? {id_inst_i[24:5], 12'b0} : {{20{id_inst_i[21]}}, id_inst_i[21:10]};

    always_comb begin
        payload_o.alu_op     = alu_op;
        payload_o.op_a       = src1;
        payload_o.op_b       = is_3r ? src2 : imm;
        payload_o.store_data = src2;
        payload_o.rd         = rd;
        payload_o.we         = is_3r | is_addi | is_lu12i | is_ld_b | is_ld_w;
        payload_o.mem_read   = is_ld_b | is_ld_w;
        payload_o.mem_write  = is_st_b | is_st_w;
        payload_o.mem_byte   = is_ld_b | is_st_b;
    end

    // b uses offs26, split as inst[9:0]:inst[25:10]
    assign br_offs = is_b ? {{4{id_inst_i[9]}}, id_inst_i[9:0], id_inst_i[25:10], 2'b00}
                          : {{14{id_inst_i[25]}}, id_inst_i[25:10], 2'b00};
    assign branch_target_o = id_pc_i + br_offs;
    assign branch_taken_o  = !stall_o &&
                             (is_b || (is_beq && src1 == src2) || (is_bne && src1 != src2));

endmodule

// ==== src/la_execute.sv ====
`timescale 1ns/100ps

module la_execute (
    input  la_pkg::id_ex_t  payload_i,
    output la_pkg::ex_mem_t payload_o,
    output la_pkg::word_t   result_o
);
    import la_pkg::*;

    word_t result;

    // loads and stores come in as add, giving the address
    always_comb begin
        case (payload_i.alu_op)
            alu_add:      result = payload_i.op_a + payload_i.op_b;
            alu_sub:      result = payload_i.op_a - payload_i.op_b;
            alu_and:      result = payload_i.op_a & payload_i.op_b;
            alu_or:       result = payload_i.op_a | payload_i.op_b;
            alu_xor:      result = payload_i.op_a ^ payload_i.op_b;
            alu_lui_pass: result = payload_i.op_b;
            default:      result = payload_i.op_a + payload_i.op_b;
        endcase
    end

    assign result_o = result;

    always_comb begin
        payload_o.result     = result;
        payload_o.store_data = payload_i.store_data;
        payload_o.rd         = payload_i.rd;
        payload_o.we         = payload_i.we;
        payload_o.mem_read   = payload_i.mem_read;
        payload_o.mem_write  = payload_i.mem_write;
        payload_o.mem_byte   = payload_i.mem_byte;
    end

endmodule

// ==== src/la_mem_access.sv ====
`timescale 1ns/100ps

module la_mem_access (
    input  la_pkg::ex_mem_t payload_i,
    input  la_pkg::word_t   ram_data_i,
    output la_pkg::word_t   ram_addr_o,
    output la_pkg::word_t   ram_data_o,
    output logic            ram_write_en_o,
    output logic [3:0]      ram_select_o,
    output logic            ram_en_o,
    output la_pkg::mem_wb_t payload_o
);
    import la_pkg::*;

    logic [7:0] lane_byte;
    word_t      load_data;

    assign ram_en_o       = payload_i.mem_read | payload_i.mem_write;
    assign ram_write_en_o = payload_i.mem_write;
    assign ram_addr_o     = payload_i.result;

    // lane 0 is the lowest byte address
    always_comb begin
        if (!ram_en_o) begin
            ram_select_o = 4'b0000;
        end else if (payload_i.mem_byte) begin
            ram_select_o = 4'b0001 << payload_i.result[1:0];
        end else begin
            ram_select_o = 4'b1111;
        end
    end

    assign ram_data_o = payload_i.mem_byte ? {4{payload_i.store_data[7:0]}}
                                           : payload_i.store_data;

    assign lane_byte = ram_data_i[8*payload_i.result[1:0] +: 8];
    assign load_data = payload_i.mem_byte ? {{24{lane_byte[7]}}, lane_byte} : ram_data_i;

    always_comb begin
        payload_o.wdata = payload_i.mem_read ? load_data : payload_i.result;
        payload_o.rd    = payload_i.rd;
        payload_o.we    = payload_i.we;
    end

endmodule

// ==== src/la_cpu.sv ====
`timescale 1ns/100ps

module la_cpu #(
    parameter la_pkg::word_t reset_pc = '0
) (
    input  logic          clk,
    input  logic          arst_n_i,
    input  la_pkg::word_t rom_inst_i,
    output la_pkg::word_t rom_inst_addr_o,
    output logic          rom_inst_en_o,
    input  la_pkg::word_t ram_data_i,
    output la_pkg::word_t ram_addr_o,
    output la_pkg::word_t ram_data_o,
    output logic          ram_write_en_o,
    output logic [3:0]    ram_select_o,
    output logic          ram_en_o
);
    import la_pkg::*;

    // fetch and decode
    word_t    id_pc;
    word_t    id_inst;
    logic     stall;
    logic     branch_taken;
    word_t    branch_target;

    // decode and regfile
    reg_idx_t rf_raddr1;
    reg_idx_t rf_raddr2;
    word_t    rf_rdata1;
    word_t    rf_rdata2;

    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;
    word_t    ex_result;

    la_fwd_if fwd ();

    assign fwd.ex_we      = ex_mem_d.we;
    assign fwd.ex_rd      = ex_mem_d.rd;
    assign fwd.ex_data    = ex_result;
    assign fwd.ex_is_load = ex_mem_d.mem_read;
    assign fwd.mem_we     = mem_wb_d.we;
    assign fwd.mem_rd     = mem_wb_d.rd;
    assign fwd.mem_data   = mem_wb_d.wdata;

    la_fetch #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .stall_i(stall),
        .branch_taken_i(branch_taken),
        .branch_target_i(branch_target),
        .rom_inst_i(rom_inst_i),
        .pc_o(rom_inst_addr_o),
        .inst_en_o(rom_inst_en_o),
        .id_pc_o(id_pc),
        .id_inst_o(id_inst)
    );

    la_decode u_decode (
        .id_pc_i(id_pc),
        .id_inst_i(id_inst),
        .rs1_data_i(rf_rdata1),
        .rs2_data_i(rf_rdata2),
        .rs1_addr_o(rf_raddr1),
        .rs2_addr_o(rf_raddr2),
        .fwd(fwd.consumer),
        .payload_o(id_ex_d),
        .stall_o(stall),
        .branch_taken_o(branch_taken),
        .branch_target_o(branch_target)
    );

    // written from the mem_wb register
    la_regfile u_regfile (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .we_i(mem_wb_q.we),
        .waddr_i(mem_wb_q.rd),
        .wdata_i(mem_wb_q.wdata),
        .raddr1_i(rf_raddr1),
        .raddr2_i(rf_raddr2),
        .rdata1_o(rf_rdata1),
        .rdata2_o(rf_rdata2)
    );

    // stalled instruction stays in decode, bubble goes on
    la_pipe_reg #(
        .payload_t(id_ex_t)
    ) u_id_ex (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .hold_i(1'b0),
        .bubble_i(stall),
        .d_i(id_ex_d),
        .q_o(id_ex_q)
    );

    la_execute u_execute (
        .payload_i(id_ex_q),
        .payload_o(ex_mem_d),
        .result_o(ex_result)
    );

    la_pipe_reg #(
        .payload_t(ex_mem_t)
    ) u_ex_mem (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .hold_i(1'b0),
        .bubble_i(1'b0),
        .d_i(ex_mem_d),
        .q_o(ex_mem_q)
    );

    la_mem_access u_mem_access (
        .payload_i(ex_mem_q),
        .ram_data_i(ram_data_i),
        .ram_addr_o(ram_addr_o),
        .ram_data_o(ram_data_o),
        .ram_write_en_o(ram_write_en_o),
        .ram_select_o(ram_select_o),
        .ram_en_o(ram_en_o),
        .payload_o(mem_wb_d)
    );

    la_pipe_reg #(
        .payload_t(mem_wb_t)
    ) u_mem_wb (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .hold_i(1'b0),
        .bubble_i(1'b0),
        .d_i(mem_wb_d),
        .q_o(mem_wb_q)
    );

endmodule

// ==== test/tb_la_ref.svh ====
`ifndef TB_LA_REF_SVH
`define TB_LA_REF_SVH

function automatic word_t enc_3r(logic [16:0] op, int rd, int rj, int rk);
    return {op, rk[4:0], rj[4:0], rd[4:0]};
endfunction

function automatic word_t enc_ri12(logic [9:0] op, int rd, int rj, int imm);
    return {op, imm[11:0], rj[4:0], rd[4:0]};
endfunction

function automatic word_t enc_lu12i(int rd, int si20);
    return {op_lu12i_w, si20[19:0], rd[4:0]};
endfunction

// beq and bne compare rj with rd, offset counted in instructions
function automatic word_t enc_br(logic [5:0] op, int rj, int rd, int offs);
    return {op, offs[15:0], rj[4:0], rd[4:0]};
endfunction

function automatic word_t enc_b(int offs);
    return {op_b, offs[15:0], offs[25:16]};
endfunction

// instruction-level model over rom and ram_init, fills exp_q with the stores
function automatic int run_model(int max_steps);
    word_t      regs [32];
    word_t      mem [ram_words];
    word_t      pc;
    word_t      pc_next;
    word_t      inst;
    word_t      a;
    word_t      b;
    word_t      d;
    word_t      addr;
    word_t      shifted;
    logic [4:0] rd;
    store_t     st;
    exp_q.delete();
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < ram_words; i++) begin
        mem[i] = ram_init[i];
    end
    pc = '0;
    for (int s = 0; s < max_steps; s++) begin
        inst    = rom[pc[7:2]];
        rd      = inst[4:0];
        a       = regs[inst[9:5]];
        b       = regs[inst[14:10]];
        d       = regs[rd];
        addr    = a + {{20{inst[21]}}, inst[21:10]};
        shifted = mem[addr[9:2]] >> {addr[1:0], 3'b000};
        pc_next = pc + 32'd4;
        if (inst[31:15] == op_add_w) begin
            regs[rd] = a + b;
        end else if (inst[31:15] == op_sub_w) begin
            regs[rd] = a - b;
        end else if (inst[31:15] == op_and) begin
            regs[rd] = a & b;
        end else if (inst[31:15] == op_or) begin
            regs[rd] = a | b;
        end else if (inst[31:15] == op_xor) begin
            regs[rd] = a ^ b;
        end else if (inst[31:22] == op_addi_w) begin
            regs[rd] = addr;
        end else if (inst[31:25] == op_lu12i_w) begin
            regs[rd] = {inst[24:5], 12'h000};
        end else if (inst[31:22] == op_ld_w) begin
            regs[rd] = mem[addr[9:2]];
        end else if (inst[31:22] == op_ld_b) begin
            regs[rd] = {{24{shifted[7]}}, shifted[7:0]};
        end else if (inst[31:22] == op_st_w) begin
            mem[addr[9:2]] = d;
            st.addr = addr;
            st.data = d;
            st.sel  = 4'b1111;
            exp_q.push_back(st);
        end else if (inst[31:22] == op_st_b) begin
            case (addr[1:0])
                2'd0: mem[addr[9:2]][7:0]   = d[7:0];
                2'd1: mem[addr[9:2]][15:8]  = d[7:0];
                2'd2: mem[addr[9:2]][23:16] = d[7:0];
                default: mem[addr[9:2]][31:24] = d[7:0];
            endcase
            st.addr = addr;
            st.data = {4{d[7:0]}};
            st.sel  = 4'b0001 << addr[1:0];
            exp_q.push_back(st);
        end else if (inst[31:26] == op_beq && a == d) begin
            pc_next = pc + {{14{inst[25]}}, inst[25:10], 2'b00};
        end else if (inst[31:26] == op_bne && a != d) begin
            pc_next = pc + {{14{inst[25]}}, inst[25:10], 2'b00};
        end else if (inst[31:26] == op_b) begin
            pc_next = pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end
        regs[0] = '0;
        pc = pc_next;
    end
    return exp_q.size();
endfunction

`endif

// ==== test/tb_la_cpu.sv ====
`timescale 1ns/100ps

module tb_la_cpu;
    import la_pkg::*;

    localparam int clk_period      = 20;
    localparam int drive_delay     = 2;
    localparam int rom_words       = 64;
    localparam int ram_words       = 256;
    localparam int idle_limit      = 60;
    localparam int model_steps     = 200;
    localparam int num_tests       = 6;
    localparam int cycles_per_test = 300;

    typedef struct packed {
        word_t      addr;
        word_t      data;
        logic [3:0] sel;
    } store_t;

    logic       clk;
    logic       arst_n_i;
    word_t      rom_inst;
    word_t      rom_addr;
    logic       rom_en;
    word_t      ram_rdata;
    word_t      ram_addr;
    word_t      ram_wdata;
    logic       ram_we;
    logic [3:0] ram_sel;
    logic       ram_en;

    word_t  rom [rom_words];
    word_t  ram [ram_words];
    word_t  ram_init [ram_words];
    store_t exp_q [$];
    int     exp_idx;
    int     idle_cycles;
    int     check_errors = 0;
    int     prog_len;
    int     pass_count;
    int     fail_count;
    int     seed = 20556;

    `include "tb_la_ref.svh"

    la_cpu uut (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .rom_inst_i(rom_inst),
        .rom_inst_addr_o(rom_addr),
        .rom_inst_en_o(rom_en),
        .ram_data_i(ram_rdata),
        .ram_addr_o(ram_addr),
        .ram_data_o(ram_wdata),
        .ram_write_en_o(ram_we),
        .ram_select_o(ram_sel),
        .ram_en_o(ram_en)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    assign rom_inst  = rom_en ? rom[rom_addr[7:2]] : '0;
    assign ram_rdata = ram_en ? ram[ram_addr[9:2]] : '0;

    // image loads during reset and stores land on the rising edge
    always @(posedge clk) begin
        if (!arst_n_i) begin
            for (int i = 0; i < ram_words; i++) begin
                ram[i] <= ram_init[i];
            end
        end else if (ram_we) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_sel[b]) begin
                    ram[ram_addr[9:2]][8*b +: 8] <= ram_wdata[8*b +: 8];
                end
            end
        end
    end

    // store compare on the falling edge
    always @(negedge clk) begin
        store_t exp_s;
        if (!arst_n_i) begin
            idle_cycles = 0;
            exp_idx = 0;
            if (rom_en !== 1'b0 || ram_en !== 1'b0 || ram_we !== 1'b0 || ram_sel !== 4'b0000) begin
                $display("** Error at %0t: strobes %b %b %b select %b in reset, expected low",
                         $time, rom_en, ram_en, ram_we, ram_sel);
                check_errors++;
            end
            if (rom_addr !== 32'h0000_0000) begin
                $display("** Error at %0t: fetch address 0x%08h in reset, expected 0x00000000",
                         $time, rom_addr);
                check_errors++;
            end
        end else if (ram_we) begin
            idle_cycles = 0;
            if (ram_en !== 1'b1) begin
                $display("** Error at %0t: store with ram_en %b, expected 1", $time, ram_en);
                check_errors++;
            end
            if (exp_idx >= exp_q.size()) begin
                $display("%0t: extra store to 0x%08h that the model does not make",
                         $time, ram_addr);
                check_errors++;
            end else begin
                exp_s = exp_q[exp_idx];
                if (ram_addr !== exp_s.addr) begin
                    $display("** Error at %0t: store %0d address 0x%08h, expected 0x%08h",
                             $time, exp_idx, ram_addr, exp_s.addr);
                    check_errors++;
                end
                if (ram_sel !== exp_s.sel) begin
                    $display("** Error at %0t: store %0d select %b, expected %b",
                             $time, exp_idx, ram_sel, exp_s.sel);
                    check_errors++;
                end
                if (ram_wdata !== exp_s.data) begin
                    $display("** Error at %0t: store %0d data 0x%08h, expected 0x%08h",
                             $time, exp_idx, ram_wdata, exp_s.data);
                    check_errors++;
                end
                exp_idx++;
            end
        end else begin
            idle_cycles++;
        end
    end

    initial begin
        #(num_tests * cycles_per_test * clk_period);
        $display("watchdog: run did not finish within %0d cycles", num_tests * cycles_per_test);
        $display("Something failed");
        $finish;
    end

    task automatic setup_test();
        for (int i = 0; i < rom_words; i++) begin
            rom[i] = '0;
        end
        // pattern spread over the whole word address
        for (int i = 0; i < ram_words; i++) begin
            ram_init[i] = 32'h9e3779b9 * (i + 1);
        end
        prog_len = 0;
    endtask

    task automatic emit(input word_t inst);
        rom[prog_len] = inst;
        prog_len++;
    endtask

    task automatic run_test(input string name);
        int n_exp;
        int errs_before;
        int missing;
        n_exp = run_model(model_steps);
        errs_before = check_errors;
        repeat (3) @(posedge clk);
        #(drive_delay);
        arst_n_i = 1'b1;
        // test is over after a quiet spell with no stores
        while (idle_cycles < idle_limit) begin
            @(posedge clk);
        end
        missing = n_exp - exp_idx;
        if (missing > 0) begin
            $display("test %s: %0d expected stores never appeared", name, missing);
        end
        if (check_errors == errs_before && missing == 0) begin
            pass_count++;
            $display("test %s: passed, %0d stores", name, n_exp);
        end else begin
            fail_count++;
            $display("test %s: failed, %0d errors", name, check_errors - errs_before + missing);
        end
        @(posedge clk);
        #(drive_delay);
        arst_n_i = 1'b0;
    endtask

    task automatic test_alu_chain();
        setup_test();
        emit(enc_ri12(op_addi_w, 1, 0, 'h123));
        emit(enc_ri12(op_addi_w, 2, 0, 'h456));
        emit(enc_3r(op_add_w, 3, 1, 2));
        emit(enc_3r(op_sub_w, 4, 3, 1));
        emit(enc_3r(op_and, 5, 4, 3));
        emit(enc_3r(op_or, 6, 5, 1));
        emit(enc_3r(op_xor, 7, 6, 4));
        emit(enc_ri12(op_addi_w, 20, 0, 'h100));
        emit(enc_ri12(op_st_w, 3, 20, 0));
        emit(enc_ri12(op_st_w, 4, 20, 4));
        emit(enc_ri12(op_st_w, 5, 20, 8));
        emit(enc_ri12(op_st_w, 6, 20, 12));
        emit(enc_ri12(op_st_w, 7, 20, 16));
        emit(enc_3r(op_add_w, 8, 7, 7));
        emit(enc_ri12(op_st_w, 8, 20, 20));
        emit(enc_b(0));
        run_test("alu chain");
    endtask

    task automatic test_immediates();
        setup_test();
        emit(enc_lu12i(1, 'h12345));
        emit(enc_ri12(op_addi_w, 1, 1, -1));
        emit(enc_lu12i(2, 'hfffff));
        emit(enc_ri12(op_addi_w, 2, 2, -2048));
        emit(enc_ri12(op_addi_w, 0, 0, 77));
        emit(enc_3r(op_add_w, 0, 1, 2));
        emit(enc_lu12i(0, 'habcde));
        emit(enc_ri12(op_addi_w, 20, 0, 'h80));
        emit(enc_ri12(op_st_w, 1, 20, 0));
        emit(enc_ri12(op_st_w, 2, 20, 4));
        emit(enc_ri12(op_st_w, 0, 20, 8));
        emit(enc_3r(op_add_w, 3, 0, 1));
        emit(enc_ri12(op_st_w, 3, 20, 12));
        emit(enc_b(0));
        run_test("immediates");
    endtask

    task automatic test_load_use();
        setup_test();
        emit(enc_ri12(op_addi_w, 20, 0, 'h40));
        emit(enc_ri12(op_ld_w, 1, 20, 0));
        emit(enc_3r(op_add_w, 2, 1, 1));
        emit(enc_ri12(op_st_w, 2, 20, 'h20));
        emit(enc_ri12(op_ld_w, 3, 20, 4));
        emit(enc_ri12(op_st_w, 3, 20, 'h24));
        emit(enc_ri12(op_ld_w, 4, 20, 8));
        emit(enc_ri12(op_addi_w, 5, 4, 1));
        emit(enc_ri12(op_st_w, 5, 20, 'h28));
        emit(enc_ri12(op_ld_w, 6, 20, 12));
        emit(enc_ri12(op_addi_w, 9, 0, 1));
        emit(enc_3r(op_add_w, 10, 6, 9));
        emit(enc_ri12(op_st_w, 10, 20, 'h2c));
        emit(enc_ri12(op_ld_w, 7, 20, 'h20));
        emit(enc_3r(op_xor, 8, 7, 5));
        emit(enc_ri12(op_st_w, 8, 20, 'h30));
        emit(enc_b(0));
        run_test("load use");
    endtask

    task automatic test_byte_access();
        setup_test();
        emit(enc_ri12(op_addi_w, 20, 0, 'h200));
        emit(enc_lu12i(1, 'h12345));
        emit(enc_ri12(op_addi_w, 1, 1, 'h0f1));
        emit(enc_ri12(op_addi_w, 2, 0, 'h082));
        emit(enc_ri12(op_addi_w, 3, 0, 'h07f));
        emit(enc_ri12(op_addi_w, 4, 0, 'h0a5));
        for (int k = 0; k < 4; k++) begin
            emit(enc_ri12(op_st_b, k + 1, 20, k));
        end
        for (int k = 0; k < 4; k++) begin
            emit(enc_ri12(op_ld_b, k + 5, 20, k));
        end
        for (int k = 0; k < 4; k++) begin
            emit(enc_ri12(op_st_w, k + 5, 20, 4 * k + 4));
        end
        emit(enc_ri12(op_ld_w, 9, 20, 0));
        emit(enc_ri12(op_st_w, 9, 20, 20));
        emit(enc_b(0));
        run_test("byte access");
    endtask

    task automatic test_branches();
        setup_test();
        emit(enc_ri12(op_addi_w, 1, 0, 5));
        emit(enc_ri12(op_addi_w, 2, 0, 5));
        emit(enc_ri12(op_addi_w, 3, 0, 7));
        emit(enc_ri12(op_addi_w, 20, 0, 'h300));
        emit(enc_br(op_beq, 1, 2, 2));
        emit(enc_ri12(op_st_w, 1, 20, 0));
        emit(enc_ri12(op_st_w, 2, 20, 4));
        emit(enc_br(op_beq, 1, 3, 2));
        emit(enc_ri12(op_st_w, 3, 20, 8));
        emit(enc_br(op_bne, 1, 3, 2));
        emit(enc_ri12(op_st_w, 3, 20, 12));
        emit(enc_br(op_bne, 1, 2, 2));
        emit(enc_ri12(op_st_w, 1, 20, 16));
        emit(enc_b(2));
        emit(enc_ri12(op_st_w, 1, 20, 20));
        emit(enc_ri12(op_addi_w, 4, 0, 5));
        emit(enc_br(op_beq, 4, 1, 2));
        emit(enc_ri12(op_st_w, 4, 20, 24));
        emit(enc_ri12(op_ld_w, 5, 20, 4));
        emit(enc_br(op_bne, 5, 1, 2));
        emit(enc_ri12(op_st_w, 5, 20, 28));
        // countdown loop of three passes
        emit(enc_ri12(op_addi_w, 6, 0, 3));
        emit(enc_ri12(op_addi_w, 6, 6, -1));
        emit(enc_ri12(op_st_w, 6, 20, 32));
        emit(enc_br(op_bne, 6, 0, -2));
        emit(enc_b(0));
        run_test("branches");
    endtask

    task automatic test_random_data();
        setup_test();
        for (int k = 0; k < 4; k++) begin
            ram_init[224 + k] = $random(seed);
        end
        emit(enc_ri12(op_addi_w, 20, 0, 'h380));
        for (int k = 0; k < 4; k++) begin
            emit(enc_ri12(op_ld_w, k + 1, 20, 4 * k));
        end
        emit(enc_3r(op_add_w, 5, 1, 2));
        emit(enc_3r(op_sub_w, 6, 3, 4));
        emit(enc_3r(op_xor, 7, 5, 6));
        emit(enc_3r(op_and, 8, 7, 1));
        emit(enc_3r(op_or, 9, 8, 4));
        for (int k = 0; k < 5; k++) begin
            emit(enc_ri12(op_st_w, k + 5, 20, 4 * k + 16));
        end
        emit(enc_ri12(op_ld_b, 10, 20, 1));
        emit(enc_ri12(op_st_w, 10, 20, 36));
        emit(enc_ri12(op_st_b, 7, 20, 42));
        emit(enc_ri12(op_ld_w, 11, 20, 40));
        emit(enc_ri12(op_st_w, 11, 20, 44));
        emit(enc_b(0));
        run_test("random data");
    endtask

    initial begin
        arst_n_i = 1'b0;
        pass_count = 0;
        fail_count = 0;
        test_alu_chain();
        test_immediates();
        test_load_use();
        test_byte_access();
        test_branches();
        test_random_data();
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== la_cpu.f ====
+incdir+test
src/la_pkg.sv
src/la_fwd_if.sv
src/la_regfile.sv
src/la_pipe_reg.sv
src/la_fetch.sv
src/la_decode.sv
src/la_execute.sv
src/la_mem_access.sv
src/la_cpu.sv
test/tb_la_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_la_cpu -f la_cpu.f

out=$(./obj_dir/Vtb_la_cpu)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Everything OK'; then
    exit 0
else
    exit 1
fi
